// ==== source/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ====================
// Geometry
// ====================
`define DC_XLEN        32
`define DC_LINE_WORDS  4
`define DC_LINE_BITS   128   // DC_XLEN * DC_LINE_WORDS
`define DC_N_WAYS      4
`define DC_N_SETS      16
`define DC_WAY_BITS    2
`define DC_SET_BITS    4
`define DC_WORD_BITS   2
`define DC_TAG_BITS    24    // Above set, word and byte bits

`endif

// ==== source/cache_geom_pkg.sv ====
`include "dcache_defs.svh"

package cache_geom_pkg;

    // Request address, whole word or lookup fields
    typedef union packed
    {
        logic [`DC_XLEN-1:0] raw;          // Memory side view
        struct packed
        {
            logic [`DC_TAG_BITS-1:0]  tag;
            logic [`DC_SET_BITS-1:0]  set;
            logic [`DC_WORD_BITS-1:0] word;  // Word in line
            logic [1:0]               byte_off;
        } fields;
    } dc_addr_u;

    // Index types
    typedef logic [`DC_SET_BITS-1:0]  dc_set_t;
    typedef logic [`DC_WAY_BITS-1:0]  dc_way_t;
    typedef logic [`DC_WORD_BITS-1:0] dc_word_t;

    // Word 0 sits in the low bits
    typedef logic [`DC_LINE_BITS-1:0] dc_line_t;

endpackage

// ==== source/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    // Controller states
    typedef enum logic [3:0]
    {
        Idle,
        Lookup,       // Tag compare, hit answered here
        Evict,        // Dirty victim out to memory
        EvictDone,
        Fill,         // Line in from memory
        FillDone,     // Line written, request answered
        FlushCheck,   // Dirty test of walk entry
        FlushWb,
        FlushNext     // Walk counter step
    } dc_state_e;

    // Data store write source
    typedef enum logic
    {
        WsrcMerge,    // Processor bytes into hit line
        WsrcFill      // Fetched line
    } dc_wsrc_e;

    // Memory address source
    typedef enum logic [1:0]
    {
        MselFill,
        MselEvict,
        MselFlush
    } dc_msel_e;

endpackage

// ==== source/dcache_flush_counter.sv ====
`timescale 1ns/1ps

module dcache_flush_counter
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     step_i,
    output cache_geom_pkg::dc_set_t  walk_set_o,
    output cache_geom_pkg::dc_way_t  walk_way_o,
    output logic                     last_o
);

    // Way in the upper bits, so the set index runs fastest
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            walk_set_o <= '0;
            walk_way_o <= '0;
        end
        else if (step_i)
            {walk_way_o, walk_set_o} <= {walk_way_o, walk_set_o} + 1'b1;  // Wraps to zero
    end

    assign last_o = (&walk_set_o) && (&walk_way_o);

endmodule

// ==== source/dcache_tag_store.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tag_store
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  cache_geom_pkg::dc_addr_u  req_addr_i,
    input  logic                      lookup_i,
    input  logic                      wr_hit_i,
    input  logic                      fill_we_i,
    input  logic                      fill_rw_i,      // Fill for a write miss
    input  logic                      flushing_i,
    input  cache_geom_pkg::dc_set_t   walk_set_i,
    input  cache_geom_pkg::dc_way_t   walk_way_i,
    input  logic                      walk_clean_i,
    output logic                      hit_o,
    output cache_geom_pkg::dc_way_t   hit_way_o,
    output cache_geom_pkg::dc_way_t   victim_way_o,
    output logic                      victim_dirty_o,
    output logic [`DC_TAG_BITS-1:0]   victim_tag_o,
    output logic                      walk_dirty_o,
    output logic [`DC_TAG_BITS-1:0]   walk_tag_o
);
    import cache_geom_pkg::*;

    logic [`DC_TAG_BITS-1:0]                tag_mem [`DC_N_SETS][`DC_N_WAYS];
    logic [`DC_N_SETS-1:0][`DC_N_WAYS-1:0]  valid_q;
    logic [`DC_N_SETS-1:0][`DC_N_WAYS-1:0]  dirty_q;
    dc_way_t [`DC_N_SETS-1:0]               fifo_q;     // Oldest way per set
    logic [`DC_N_WAYS-1:0]                  way_hit;
    dc_set_t                                set;

    assign set = req_addr_i.fields.set;

    // Compare across all ways of the set
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < `DC_N_WAYS; w++)
        begin
            way_hit[w] = valid_q[set][w] && (tag_mem[set][w] == req_addr_i.fields.tag);
            if (way_hit[w])
                hit_way_o = dc_way_t'(w);
        end
    end

    assign hit_o = lookup_i && (|way_hit);

    assign victim_way_o   = fifo_q[set];
    assign victim_dirty_o = dirty_q[set][victim_way_o];   // Dirty implies valid
    assign victim_tag_o   = tag_mem[set][victim_way_o];
    assign walk_dirty_o   = dirty_q[walk_set_i][walk_way_i];
    assign walk_tag_o     = tag_mem[walk_set_i][walk_way_i];

    always_ff @(posedge clk_i)
    begin
        if (fill_we_i)
            tag_mem[set][victim_way_o] <= req_addr_i.fields.tag;
    end

    // ====================
    // Valid, dirty, FIFO
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            valid_q <= '0;
            dirty_q <= '0;
            fifo_q  <= '0;
        end
        else if (fill_we_i)
        begin
            valid_q[set][victim_way_o] <= 1'b1;
            dirty_q[set][victim_way_o] <= fill_rw_i;
            fifo_q[set]                <= victim_way_o + 1'b1;   // Next oldest
        end
        else if (wr_hit_i)
            dirty_q[set][hit_way_o] <= 1'b1;
        else if (walk_clean_i && flushing_i)
            dirty_q[walk_set_i][walk_way_i] <= 1'b0;   // Line now in memory
    end

endmodule

// ==== source/dcache_data_store.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_data_store
(
    input  logic                      clk_i,
    input  cache_geom_pkg::dc_addr_u  req_addr_i,
    input  logic [`DC_XLEN/8-1:0]     req_be_i,
    input  logic [`DC_XLEN-1:0]       req_data_i,
    input  logic                      wr_hit_i,
    input  cache_geom_pkg::dc_way_t   hit_way_i,
    input  logic                      fill_we_i,
    input  cache_geom_pkg::dc_way_t   victim_way_i,
    input  cache_geom_pkg::dc_line_t  fill_line_i,
    input  logic                      fill_rw_i,
    input  cache_geom_pkg::dc_set_t   walk_set_i,
    input  cache_geom_pkg::dc_way_t   walk_way_i,
    input  logic                      flushing_i,
    output logic [`DC_XLEN-1:0]       rd_word_o,
    output cache_geom_pkg::dc_line_t  evict_line_o
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    dc_line_t             line_mem [`DC_N_SETS][`DC_N_WAYS];
    dc_set_t              set;
    dc_word_t             word;
    dc_wsrc_e             wsrc;
    dc_way_t              wr_way;
    dc_line_t             base_line;   // Hit line or fetched line
    dc_line_t             wr_line;
    logic [`DC_XLEN-1:0]  old_word;
    logic [`DC_XLEN-1:0]  new_word;

    assign set  = req_addr_i.fields.set;
    assign word = req_addr_i.fields.word;
    assign wsrc = fill_we_i ? WsrcFill : WsrcMerge;

    assign wr_way    = (wsrc == WsrcFill) ? victim_way_i : hit_way_i;
    assign base_line = (wsrc == WsrcFill) ? fill_line_i : line_mem[set][hit_way_i];
    assign old_word  = base_line[word*`DC_XLEN +: `DC_XLEN];
    assign rd_word_o = old_word;   // Hit word, or fetched word in FillDone

    // ====================
    // Byte merge
    // ====================
    always_comb
    begin
        for (int b = 0; b < `DC_XLEN/8; b++)
            new_word[b*8 +: 8] = req_be_i[b] ? req_data_i[b*8 +: 8] : old_word[b*8 +: 8];
        wr_line = base_line;
        for (int w = 0; w < `DC_LINE_WORDS; w++)
        begin
            if (fill_rw_i && dc_word_t'(w) == word)   // Read fills stay untouched
                wr_line[w*`DC_XLEN +: `DC_XLEN] = new_word;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (wr_hit_i || fill_we_i)
            line_mem[set][wr_way] <= wr_line;
    end

    // Victim line, or walk entry during flush
    assign evict_line_o = flushing_i ? line_mem[walk_set_i][walk_way_i]
                                     : line_mem[set][victim_way_i];

endmodule

// ==== source/dcache_mem_port.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_mem_port
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      evict_req_i,
    input  logic                      fill_req_i,
    input  logic                      flush_wb_req_i,
    input  cache_geom_pkg::dc_addr_u  req_addr_i,
    input  logic [`DC_TAG_BITS-1:0]   victim_tag_i,
    input  logic [`DC_TAG_BITS-1:0]   walk_tag_i,
    input  cache_geom_pkg::dc_set_t   walk_set_i,
    input  cache_geom_pkg::dc_line_t  evict_line_i,
    input  logic [`DC_LINE_BITS-1:0]  m_data_i,
    input  logic                      m_ready_i,
    output logic [`DC_XLEN-1:0]       m_addr_o,
    output logic [`DC_LINE_BITS-1:0]  m_data_o,
    output logic                      m_strobe_o,
    output logic                      m_rw_o,
    output cache_geom_pkg::dc_line_t  fill_line_o,
    output logic                      mem_done_o
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    dc_msel_e  msel;
    dc_addr_u  line_addr;
    logic      start;

    // Requests are levels, so only launch when nothing is in flight
    assign start = (evict_req_i || fill_req_i || flush_wb_req_i) && !m_strobe_o;
    assign msel  = flush_wb_req_i ? MselFlush : (evict_req_i ? MselEvict : MselFill);

    // Line address built through the lookup fields
    always_comb
    begin
        line_addr = req_addr_i;
        case (msel)
            MselEvict:
                line_addr.fields.tag = victim_tag_i;
            MselFlush:
            begin
                line_addr.fields.tag = walk_tag_i;
                line_addr.fields.set = walk_set_i;
            end
            default: ;
        endcase
        line_addr.fields.word     = '0;
        line_addr.fields.byte_off = '0;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            m_strobe_o <= 1'b0;
        else if (start)
            m_strobe_o <= 1'b1;
        else if (m_ready_i)
            m_strobe_o <= 1'b0;   // Falls the cycle after ready
    end

    // ====================
    // Payload
    // ====================
    always_ff @(posedge clk_i)
    begin
        if (start)
        begin
            m_addr_o <= line_addr.raw;
            m_data_o <= evict_line_i;
            m_rw_o   <= (msel != MselFill);
        end
        if (mem_done_o && !m_rw_o)
            fill_line_o <= m_data_i;   // Ready for FillDone
    end

    assign mem_done_o = m_strobe_o && m_ready_i;

endmodule

// ==== source/dcache_fsm.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_fsm
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      p_strobe_i,
    input  logic                      p_rw_i,
    input  logic [`DC_XLEN-1:0]       p_addr_i,
    input  logic [`DC_XLEN/8-1:0]     p_byte_en_i,
    input  logic [`DC_XLEN-1:0]       p_data_i,
    input  logic                      p_flush_i,
    input  logic                      hit_i,
    input  logic                      victim_dirty_i,
    input  logic                      walk_dirty_i,
    input  logic                      mem_done_i,
    input  logic                      last_i,         // Final walk entry
    output cache_geom_pkg::dc_addr_u  req_addr_o,
    output logic                      req_rw_o,
    output logic [`DC_XLEN/8-1:0]     req_be_o,
    output logic [`DC_XLEN-1:0]       req_data_o,
    output logic                      lookup_o,
    output logic                      wr_hit_o,
    output logic                      fill_we_o,
    output logic                      evict_req_o,
    output logic                      fill_req_o,
    output logic                      flush_wb_req_o,
    output logic                      flushing_o,
    output logic                      cnt_step_o,
    output logic                      p_ready_o,
    output logic                      busy_flushing_o
);
    import cache_ctrl_pkg::*;

    dc_state_e state_q, state_d;

    // Request capture, only on a strobe while idle
    always_ff @(posedge clk_i)
    begin
        if (state_q == Idle && p_strobe_i)
        begin
            req_addr_o.raw <= p_addr_i;
            req_rw_o       <= p_rw_i;
            req_be_o       <= p_byte_en_i;
            req_data_o     <= p_data_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= Idle;
        else
            state_q <= state_d;
    end

    // ====================
    // Next state
    // ====================
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            Idle:
                if (p_flush_i)
                    state_d = FlushCheck;   // Flush wins over a strobe
                else if (p_strobe_i)
                    state_d = Lookup;
            Lookup:
                if (hit_i)
                    state_d = Idle;
                else
                    state_d = victim_dirty_i ? Evict : Fill;
            Evict:      state_d = mem_done_i ? EvictDone : Evict;
            EvictDone:  state_d = Fill;
            Fill:       state_d = mem_done_i ? FillDone : Fill;
            FillDone:   state_d = Idle;
            FlushCheck: state_d = walk_dirty_i ? FlushWb : FlushNext;
            FlushWb:    state_d = mem_done_i ? FlushNext : FlushWb;
            FlushNext:  state_d = last_i ? Idle : FlushCheck;
            default:    state_d = Idle;
        endcase
    end

    // High from the cycle after p_flush_i through the last ready
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            busy_flushing_o <= 1'b0;
        else if (state_q == Idle && p_flush_i)
            busy_flushing_o <= 1'b1;
        else if (state_q == FlushNext && last_i)
            busy_flushing_o <= 1'b0;
    end

    // ====================
    // Decoded controls
    // ====================
    assign lookup_o       = (state_q == Lookup);
    assign wr_hit_o       = lookup_o && hit_i && req_rw_o;
    assign fill_we_o      = (state_q == FillDone);
    assign evict_req_o    = (state_q == Evict);
    assign fill_req_o     = (state_q == Fill);
    assign flush_wb_req_o = (state_q == FlushWb);
    assign cnt_step_o     = (state_q == FlushNext);
    assign flushing_o     = (state_q == FlushCheck) || flush_wb_req_o || cnt_step_o;

    assign p_ready_o = (lookup_o && hit_i) || fill_we_o || (cnt_step_o && last_i);

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Processor side
    input  logic                      p_strobe_i,
    input  logic                      p_rw_i,        // 1 for write
    input  logic [`DC_XLEN/8-1:0]     p_byte_en_i,
    input  logic [`DC_XLEN-1:0]       p_addr_i,
    input  logic [`DC_XLEN-1:0]       p_data_i,
    input  logic                      p_flush_i,
    output logic [`DC_XLEN-1:0]       p_data_o,
    output logic                      p_ready_o,
    output logic                      busy_flushing_o,
    // Memory side
    output logic [`DC_XLEN-1:0]       m_addr_o,
    output logic [`DC_LINE_BITS-1:0]  m_data_o,
    output logic                      m_strobe_o,
    output logic                      m_rw_o,
    input  logic [`DC_LINE_BITS-1:0]  m_data_i,
    input  logic                      m_ready_i
);
    import cache_geom_pkg::*;

    // Latched request
    dc_addr_u                  req_addr;
    logic                      req_rw;
    logic [`DC_XLEN/8-1:0]     req_be;
    logic [`DC_XLEN-1:0]       req_data;

    // Controls from the FSM
    logic lookup, wr_hit, fill_we, flushing, cnt_step;
    logic evict_req, fill_req, flush_wb_req;

    // Status back to the FSM
    logic hit, victim_dirty, walk_dirty, mem_done, last;

    dc_way_t                   hit_way, victim_way, walk_way;
    dc_set_t                   walk_set;
    logic [`DC_TAG_BITS-1:0]   victim_tag, walk_tag;
    dc_line_t                  fill_line, evict_line;

    dcache_fsm fsm_i
    (
        .clk_i, .rst_i, .p_strobe_i, .p_rw_i, .p_addr_i, .p_byte_en_i, .p_data_i,
        .p_flush_i,
        .hit_i(hit), .victim_dirty_i(victim_dirty), .walk_dirty_i(walk_dirty),
        .mem_done_i(mem_done), .last_i(last),
        .req_addr_o(req_addr), .req_rw_o(req_rw), .req_be_o(req_be),
        .req_data_o(req_data), .lookup_o(lookup), .wr_hit_o(wr_hit),
        .fill_we_o(fill_we), .evict_req_o(evict_req), .fill_req_o(fill_req),
        .flush_wb_req_o(flush_wb_req), .flushing_o(flushing), .cnt_step_o(cnt_step),
        .p_ready_o, .busy_flushing_o
    );

    dcache_flush_counter walk_cnt_i
    (
        .clk_i, .rst_i, .step_i(cnt_step),
        .walk_set_o(walk_set), .walk_way_o(walk_way), .last_o(last)
    );

    dcache_tag_store tag_i
    (
        .clk_i, .rst_i, .req_addr_i(req_addr), .lookup_i(lookup), .wr_hit_i(wr_hit),
        .fill_we_i(fill_we), .fill_rw_i(req_rw), .flushing_i(flushing),
        .walk_set_i(walk_set), .walk_way_i(walk_way),
        .walk_clean_i(mem_done),                      // Write-back finished
        .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
        .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag),
        .walk_dirty_o(walk_dirty), .walk_tag_o(walk_tag)
    );

    dcache_data_store data_i
    (
        .clk_i, .req_addr_i(req_addr), .req_be_i(req_be), .req_data_i(req_data),
        .wr_hit_i(wr_hit), .hit_way_i(hit_way), .fill_we_i(fill_we),
        .victim_way_i(victim_way), .fill_line_i(fill_line), .fill_rw_i(req_rw),
        .walk_set_i(walk_set), .walk_way_i(walk_way), .flushing_i(flushing),
        .rd_word_o(p_data_o), .evict_line_o(evict_line)
    );

    dcache_mem_port mem_i
    (
        .clk_i, .rst_i, .evict_req_i(evict_req), .fill_req_i(fill_req),
        .flush_wb_req_i(flush_wb_req), .req_addr_i(req_addr),
        .victim_tag_i(victim_tag), .walk_tag_i(walk_tag), .walk_set_i(walk_set),
        .evict_line_i(evict_line), .m_data_i, .m_ready_i,
        .m_addr_o, .m_data_o, .m_strobe_o, .m_rw_o,
        .fill_line_o(fill_line), .mem_done_o(mem_done)
    );

endmodule

// ==== verification/dcache_asserts.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_asserts
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      strobe_i,    // Memory request
    input  logic                      ready_i,     // Memory answer
    input  logic                      rw_i,
    input  logic [`DC_XLEN-1:0]       addr_i,
    input  logic [`DC_LINE_BITS-1:0]  wdata_i,
    input  logic                      p_ready_i
);

    // Strobe only falls after the answer
    strobe_held: assert property (@(posedge clk_i) disable iff (rst_i)
        strobe_i && !ready_i |=> strobe_i)
        else $error("Memory strobe dropped without a ready");

    // Payload frozen while waiting
    payload_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        strobe_i && !ready_i |=> $stable(addr_i) && $stable(wdata_i) && $stable(rw_i))
        else $error("Memory address, data or rw changed while the request waited");

    ready_single: assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_i |=> !p_ready_i)
        else $error("Processor ready high two cycles in a row");

endmodule

bind dcache_top dcache_asserts asserts_i
(
    .clk_i, .rst_i, .strobe_i(m_strobe_o), .ready_i(m_ready_i), .rw_i(m_rw_o),
    .addr_i(m_addr_o), .wdata_i(m_data_o), .p_ready_i(p_ready_o)
);

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tb;

    localparam int clk_period    = 100;
    localparam int mem_lines_n   = 4096;   // 64 KB behind the cache
    localparam int ready_timeout = 100;    // Cycles per access or flush step
    // About 30 accesses of up to 16 cycles and a flush of 64 entries at up to
    // 9 cycles each stay far below 2000 cycles
    localparam int watchdog_cycles = 2000;

    logic                      clk_i;
    logic                      rst_i;
    logic                      p_strobe_i;
    logic                      p_rw_i;
    logic [`DC_XLEN/8-1:0]     p_byte_en_i;
    logic [`DC_XLEN-1:0]       p_addr_i;
    logic [`DC_XLEN-1:0]       p_data_i;
    logic                      p_flush_i;
    logic [`DC_XLEN-1:0]       p_data_o;
    logic                      p_ready_o;
    logic                      busy_flushing_o;
    logic [`DC_XLEN-1:0]       m_addr_o;
    logic [`DC_LINE_BITS-1:0]  m_data_o;
    logic                      m_strobe_o;
    logic                      m_rw_o;
    logic [`DC_LINE_BITS-1:0]  m_data_i;
    logic                      m_ready_i;

    logic [`DC_LINE_BITS-1:0]  mem_lines [mem_lines_n];   // Memory model
    logic [15:0]               lfsr_q;
    logic [31:0]               mem_delay;
    int                        line_idx;
    int                        errors;
    int                        checks;
    int                        mem_writes;                // Lines written by the cache
    logic [31:0]               addr_a;
    logic [31:0]               exp_a;                     // Current value at addr_a

    dcache_top dut_i
    (
        .clk_i, .rst_i, .p_strobe_i, .p_rw_i, .p_byte_en_i, .p_addr_i, .p_data_i,
        .p_flush_i, .p_data_o, .p_ready_o, .busy_flushing_o,
        .m_addr_o, .m_data_o, .m_strobe_o, .m_rw_o, .m_data_i, .m_ready_i
    );

    initial clk_i = 1'b0;
    always #(clk_period/2) clk_i = ~clk_i;

    // ====================
    // Helpers
    // ====================
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val    = {val[30:0], lfsr_q[15]};   // One step per bit
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return mem_lines[addr[15:4]][addr[3:2]*32 +: 32];
    endfunction

    task automatic check_word(input string test, input logic [31:0] exp,
                              input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("Error in %s: expected %h, actual %h", test, exp, act);
        end
    endtask

    task automatic check_cond(input string test, input logic ok, input string what);
        checks++;
        assert (ok === 1'b1)
        else
        begin
            errors++;
            $display("Failure in %s: %s", test, what);
        end
    endtask

    // One processor request with its latency in cycles after the strobe
    task automatic cpu_access(input string test, input logic rw, input logic [31:0] addr,
                              input logic [3:0] be, input logic [31:0] wdata,
                              output logic [31:0] rdata, output int lat);
        rdata = '0;
        @(negedge clk_i);
        p_strobe_i  = 1'b1;
        p_rw_i      = rw;
        p_addr_i    = addr;
        p_byte_en_i = be;
        p_data_i    = wdata;
        @(negedge clk_i);
        p_strobe_i = 1'b0;   // Single-cycle pulse
        lat = 1;
        while (!p_ready_o && lat < ready_timeout)
        begin
            @(negedge clk_i);
            lat++;
        end
        check_cond(test, p_ready_o, "the cache never raised p_ready_o for the request");
        rdata = p_data_o;
    endtask

    // Memory answers 1 to 4 cycles after the strobe
    always
    begin
        @(negedge clk_i);
        if (m_strobe_o)
        begin
            draw_bits(2, mem_delay);
            repeat (mem_delay) @(negedge clk_i);
            check_cond("mem_port", m_addr_o[3:0] == 4'h0 && m_addr_o[31:16] == 16'h0,
                       "the memory address was not a line address inside the model");
            line_idx = int'(m_addr_o[15:4]);
            if (m_rw_o)
            begin
                mem_lines[line_idx] = m_data_o;
                mem_writes++;
            end
            else
                m_data_i = mem_lines[line_idx];
            m_ready_i = 1'b1;
            @(negedge clk_i);
            m_ready_i = 1'b0;   // One cycle only
        end
    end

    // ====================
    // Directed tests
    // ====================
    task automatic read_miss();
        logic [31:0] rdata;
        int          lat;
        cpu_access("read_miss", 1'b0, addr_a, 4'h0, '0, rdata, lat);
        check_word("read_miss", exp_a, rdata);
        check_cond("read_miss", lat > 1, "a read of a cold line was answered as a hit");
    endtask

    task automatic read_hit();
        logic [31:0] rdata;
        int          lat;
        cpu_access("read_hit", 1'b0, addr_a, 4'h0, '0, rdata, lat);
        check_word("read_hit", exp_a, rdata);
        check_word("read_hit", 32'd1, lat);   // Answered in Lookup
    endtask

    task automatic byte_write();
        logic [31:0] rdata;
        logic [31:0] wdata;
        int          lat;
        draw_bits(32, wdata);
        cpu_access("byte_write", 1'b1, addr_a, 4'b0110, wdata, rdata, lat);
        check_word("byte_write", 32'd1, lat);
        exp_a = merge_bytes(exp_a, wdata, 4'b0110);
        cpu_access("byte_write", 1'b0, addr_a, 4'h0, '0, rdata, lat);
        check_word("byte_write", exp_a, rdata);
    endtask

    // Six lines in set 5 with the dirty first fill as FIFO victim
    task automatic fifo_evict();
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic [31:0] base;
        int          lat;
        int          writes_before;
        base = 32'h0000_0058;   // Set 5, word 2
        draw_bits(32, wdata);
        cpu_access("fifo_evict", 1'b1, base, 4'hF, wdata, rdata, lat);
        check_cond("fifo_evict", lat > 1, "a write to a cold line was answered as a hit");
        for (int k = 1; k <= 4; k++)
        begin
            cpu_access("fifo_evict", 1'b0, base + k*32'h100, 4'h0, '0, rdata, lat);
            check_word("fifo_evict", base + k*32'h100, rdata);
        end
        check_word("fifo_evict", wdata, mem_word(base));            // Written back
        check_word("fifo_evict", base + 32'd4, mem_word(base + 32'd4));
        writes_before = mem_writes;
        cpu_access("fifo_evict", 1'b0, base + 32'h500, 4'h0, '0, rdata, lat);
        check_word("fifo_evict", base + 32'h500, rdata);
        check_cond("fifo_evict", mem_writes == writes_before,
                   "a clean victim was written back to memory");
        cpu_access("fifo_evict", 1'b0, base, 4'h0, '0, rdata, lat);
        check_word("fifo_evict", wdata, rdata);
        check_cond("fifo_evict", lat > 1, "the evicted line was still answered as a hit");
    endtask

    task automatic flush_walk();
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic [31:0] addr_c0;
        logic [31:0] addr_c1;
        logic [31:0] exp_c0;
        logic [31:0] exp_c1;
        logic        busy_ok;
        int          lat;
        int          cycles;
        int          writes_before;
        addr_c0 = 32'h0000_0390;   // Set 9, word 0
        addr_c1 = 32'h0000_0A3C;   // Set 3, word 3
        draw_bits(32, wdata);
        cpu_access("flush_walk", 1'b1, addr_c0, 4'b1000, wdata, rdata, lat);
        exp_c0 = merge_bytes(addr_c0, wdata, 4'b1000);
        draw_bits(32, wdata);
        cpu_access("flush_walk", 1'b1, addr_c1, 4'b0011, wdata, rdata, lat);
        exp_c1 = merge_bytes(addr_c1, wdata, 4'b0011);
        writes_before = mem_writes;
        @(negedge clk_i);
        p_flush_i = 1'b1;
        @(negedge clk_i);
        p_flush_i = 1'b0;
        busy_ok = 1'b1;
        cycles  = 1;
        while (!p_ready_o && cycles < 64*ready_timeout)
        begin
            busy_ok = busy_ok && busy_flushing_o;
            @(negedge clk_i);
            cycles++;
        end
        busy_ok = busy_ok && busy_flushing_o;   // Still high in the ready cycle
        check_cond("flush_walk", p_ready_o, "the flush never raised p_ready_o");
        check_cond("flush_walk", busy_ok, "busy_flushing_o dropped before the final ready");
        @(negedge clk_i);
        check_cond("flush_walk", !busy_flushing_o, "busy_flushing_o stayed high after ready");
        check_word("flush_walk", 32'd3, mem_writes - writes_before);   // Lines A, C0, C1
        check_word("flush_walk", exp_a, mem_word(addr_a));
        check_word("flush_walk", exp_c0, mem_word(addr_c0));
        check_word("flush_walk", exp_c1, mem_word(addr_c1));
        // C1 is clean now and leaves set 3 without a write-back
        writes_before = mem_writes;
        for (int k = 1; k <= 4; k++)
            cpu_access("flush_walk", 1'b0, addr_c1 + k*32'h100, 4'h0, '0, rdata, lat);
        check_cond("flush_walk", mem_writes == writes_before,
                   "a line cleaned by the flush was written back again");
        cpu_access("flush_walk", 1'b0, addr_c1, 4'h0, '0, rdata, lat);
        check_word("flush_walk", exp_c1, rdata);
        check_cond("flush_walk", lat > 1, "the flushed line was not refetched from memory");
    endtask

    // ====================
    // Sequence
    // ====================
    initial
    begin
        p_strobe_i  = 1'b0;
        p_rw_i      = 1'b0;
        p_byte_en_i = '0;
        p_addr_i    = '0;
        p_data_i    = '0;
        p_flush_i   = 1'b0;
        m_data_i    = '0;
        m_ready_i   = 1'b0;
        rst_i       = 1'b1;
        errors      = 0;
        checks      = 0;
        mem_writes  = 0;
        lfsr_q      = 16'd71;
        addr_a      = 32'h0000_0124;   // Set 2, word 1
        exp_a       = addr_a;
        for (int i = 0; i < mem_lines_n; i++)
        begin
            for (int w = 0; w < 4; w++)
                mem_lines[i][w*32 +: 32] = i*16 + w*4;   // Word holds its byte address
        end
        repeat (3) @(negedge clk_i);
        rst_i = 1'b0;
        read_miss();
        read_hit();
        byte_write();
        fifo_evict();
        flush_walk();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== dcache_top.f ====
+incdir+source
source/cache_geom_pkg.sv
source/cache_ctrl_pkg.sv
source/dcache_flush_counter.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_mem_port.sv
source/dcache_fsm.sv
source/dcache_top.sv
verification/dcache_asserts.sv
verification/dcache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = dcache_tb
FILELIST  = dcache_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Verification failed
PASS_MSG  = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
